// File: design/rob_cfg_apb.sv
`timescale 1ns/1ps

module rob_cfg_apb import rob_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  word_t     paddr_i,
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  word_t     pwdata_i,
  output word_t     prdata_o,
  output logic      pready_o,
  output logic      pslverr_o,
  output rob_cfg_t  cfg_o,
  input  rob_stat_t stat_i
);

  localparam word_t ADDR_CTRL    = 32'h0;
  localparam word_t ADDR_STATUS  = 32'h4;
  localparam word_t ADDR_RETIRED = 32'h8;

  rob_cfg_t cfg_q;
  word_t    retired_q;
  word_t    retire_add;
  logic     access, wr_en;
  logic     hit_ctrl, hit_status, hit_retired, mapped;

  assign access      = psel_i & penable_i;  // access phase only
  assign wr_en       = access & pwrite_i;
  assign hit_ctrl    = paddr_i == ADDR_CTRL;
  assign hit_status  = paddr_i == ADDR_STATUS;
  assign hit_retired = paddr_i == ADDR_RETIRED;
  assign mapped      = hit_ctrl | hit_status | hit_retired;

  assign retire_add = word_t'(stat_i.retire[0]) + word_t'(stat_i.retire[1]);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      cfg_q.dispatch_en <= 1'b1;
      cfg_q.reserve     <= '0;
      retired_q         <= '0;
    end
    else
    begin
      if (wr_en && hit_ctrl)
      begin
        cfg_q.dispatch_en <= pwdata_i[0];
        cfg_q.reserve     <= pwdata_i[4 +: ROB_LEN];
      end
      // clear wins over this cycle's retirements
      if (wr_en && hit_retired)
      begin
        retired_q <= '0;
      end
      else
      begin
        retired_q <= retired_q + retire_add;
      end
    end
  end

  always_comb
  begin
    prdata_o = '0;
    if (hit_ctrl)
    begin
      prdata_o[0]            = cfg_q.dispatch_en;
      prdata_o[4 +: ROB_LEN] = cfg_q.reserve;
    end
    else if (hit_status)
    begin
      prdata_o = word_t'(stat_i.occupancy);
    end
    else if (hit_retired)
    begin
      prdata_o = retired_q;
    end
  end

  assign pready_o  = 1'b1;  // no wait states
  assign pslverr_o = access & ~mapped;
  assign cfg_o     = cfg_q;

endmodule

// File: design/rob_core.sv
`timescale 1ns/1ps

module rob_core import rob_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  rob_cfg_t             cfg_i,
  output rob_stat_t            stat_o,
  input  logic           [1:0] disp_valid_i,
  input  dispatch_info_t [1:0] disp_info_i,
  output logic                 disp_ready_o,
  output rob_rid_t       [1:0] disp_rid_o,
  input  cdb_t           [1:0] cdb_i,
  input  rob_rid_t       [3:0] op_rid_i,
  output logic           [3:0] op_done_o,
  output word_t          [3:0] op_data_o,
  output rob_entry_t     [1:0] commit_entry_o,
  output logic           [1:0] commit_valid_o,
  input  logic           [1:0] retire_i
);

  localparam int DEPTH = 1 << ROB_LEN;
  localparam int FW    = ROB_LEN + 2;  // room for 2 + reserve

  logic           [1:0]   disp_we;
  rob_rid_t       [1:0]   head_rid;
  logic           [ROB_LEN:0] occupancy;
  logic           [FW-1:0] free_cnt, need_cnt;
  logic           [1:0]   cdb_we;
  rob_rid_t       [1:0]   cdb_rid;
  word_t          [1:0]   cdb_wdata;
  rob_dynamic_t   [1:0]   cdb_dyn;
  dispatch_info_t [1:0]   head_static;
  rob_dynamic_t   [1:0]   head_dyn;
  word_t          [5:0]   data_rd;   // [5:4] head, [3:0] operands

  assign free_cnt     = FW'(DEPTH) - FW'(occupancy);
  assign need_cnt     = FW'(2) + FW'(cfg_i.reserve);
  assign disp_ready_o = cfg_i.dispatch_en && (free_cnt >= need_cnt);
  assign disp_we      = disp_valid_i & {2{disp_ready_o}};

  always_comb
  begin
    for (int i = 0; i < 2; i++)
    begin
      cdb_we[i]            = cdb_i[i].valid;
      cdb_rid[i]           = cdb_i[i].rid;
      cdb_wdata[i]         = cdb_i[i].wdata;
      cdb_dyn[i].need_jump = cdb_i[i].need_jump;
      cdb_dyn[i].target    = cdb_i[i].target;
    end
  end

  rob_pointers u_pointers (
    .clk       (clk),
    .rst_n     (rst_n),
    .alloc_i   (disp_we),
    .retire_i  (retire_i),
    .tail_rid_o(disp_rid_o),
    .head_rid_o(head_rid)
  );

  rob_valid_tracker u_valid (
    .clk           (clk),
    .rst_n         (rst_n),
    .disp_we_i     (disp_we),
    .disp_rid_i    (disp_rid_o),
    .cdb_i         (cdb_i),
    .op_rid_i      (op_rid_i),
    .head_rid_i    (head_rid),
    .retire_i      (retire_i),
    .op_done_o     (op_done_o),
    .commit_valid_o(commit_valid_o),
    .occupancy_o   (occupancy)
  );

  rob_regfile_banked #(
    .DATA_WIDTH($bits(dispatch_info_t)),
    .DEPTH     (DEPTH),
    .R_PORTS   (2),
    .W_PORTS   (2)
  ) u_static_tbl (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr_i(head_rid),
    .rdata_o(head_static),
    .waddr_i(disp_rid_o),
    .we_i   (disp_we),
    .wdata_i(disp_info_i)
  );

  rob_regfile_banked #(
    .DATA_WIDTH($bits(word_t)),
    .DEPTH     (DEPTH),
    .R_PORTS   (6),
    .W_PORTS   (2)
  ) u_data_tbl (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr_i({head_rid, op_rid_i}),
    .rdata_o(data_rd),
    .waddr_i(cdb_rid),
    .we_i   (cdb_we),
    .wdata_i(cdb_wdata)
  );

  rob_regfile_banked #(
    .DATA_WIDTH($bits(rob_dynamic_t)),
    .DEPTH     (DEPTH),
    .R_PORTS   (2),
    .W_PORTS   (2)
  ) u_dyn_tbl (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr_i(head_rid),
    .rdata_o(head_dyn),
    .waddr_i(cdb_rid),
    .we_i   (cdb_we),
    .wdata_i(cdb_dyn)
  );

  assign op_data_o = data_rd[3:0];

  always_comb
  begin
    for (int i = 0; i < 2; i++)
    begin
      commit_entry_o[i] = gather_rob(head_static[i], head_dyn[i], data_rd[4+i],
                                     commit_valid_o[i]);
    end
  end

  assign stat_o.occupancy = occupancy;
  assign stat_o.retire    = retire_i;

endmodule

// File: design/rob_pkg.sv
package rob_pkg;

  localparam int ROB_LEN = 3;  // 8 entries

  typedef logic [31:0]        word_t;
  typedef logic [ROB_LEN-1:0] rob_rid_t;
  typedef logic [4:0]         arch_rid_t;
  typedef logic [3:0]         excp_t;

  // static part, written once at dispatch
  typedef struct packed {
    word_t     pc;
    arch_rid_t wreg;
    excp_t     excp;
  } dispatch_info_t;

  typedef struct packed {
    logic     valid;
    rob_rid_t rid;
    word_t    wdata;
    logic     need_jump;
    word_t    target;
  } cdb_t;

  // written back from the cdb together with the result word
  typedef struct packed {
    logic  need_jump;
    word_t target;
  } rob_dynamic_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    arch_rid_t wreg;
    excp_t     excp;
    word_t     wdata;
    logic      need_jump;
    word_t     target;
  } rob_entry_t;

  typedef struct packed {
    logic               dispatch_en;
    logic [ROB_LEN-1:0] reserve;  // extra free entries held back from dispatch
  } rob_cfg_t;

  typedef struct packed {
    logic [ROB_LEN:0] occupancy;
    logic [1:0]       retire;
  } rob_stat_t;

  function automatic rob_entry_t gather_rob(dispatch_info_t static_i, rob_dynamic_t dynamic_i,
                                            word_t data_i, logic valid_i);
    rob_entry_t ret;
    ret.valid     = valid_i;
    ret.pc        = static_i.pc;
    ret.wreg      = static_i.wreg;
    ret.excp      = static_i.excp;
    ret.wdata     = data_i;
    ret.need_jump = dynamic_i.need_jump;
    ret.target    = dynamic_i.target;
    return ret;
  endfunction

endpackage

// File: design/rob_pointers.sv
`timescale 1ns/1ps

module rob_pointers import rob_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  input  logic     [1:0] alloc_i,
  input  logic     [1:0] retire_i,
  output rob_rid_t [1:0] tail_rid_o,
  output rob_rid_t [1:0] head_rid_o
);

  rob_rid_t tail_q;
  rob_rid_t head_q;

  // wrap comes for free from the rid width
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      tail_q <= '0;
      head_q <= '0;
    end
    else
    begin
      tail_q <= tail_q + rob_rid_t'(alloc_i[0]) + rob_rid_t'(alloc_i[1]);
      head_q <= head_q + rob_rid_t'(retire_i[0]) + rob_rid_t'(retire_i[1]);
    end
  end

  assign tail_rid_o[0] = tail_q;
  assign tail_rid_o[1] = tail_q + rob_rid_t'(1);
  assign head_rid_o[0] = head_q;
  assign head_rid_o[1] = head_q + rob_rid_t'(1);  // second oldest

  // in-order retirement
  a_retire_order: assert property (@(posedge clk) disable iff (!rst_n)
    retire_i[1] |-> retire_i[0]);

endmodule

// File: design/rob_regfile_banked.sv
`timescale 1ns/1ps

module rob_regfile_banked #(
  parameter int DATA_WIDTH = 32,
  parameter int DEPTH      = 8,
  parameter int R_PORTS    = 2,
  parameter int W_PORTS    = 2,
  localparam int AW        = $clog2(DEPTH)
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [R_PORTS-1:0][AW-1:0]          raddr_i,
  output logic [R_PORTS-1:0][DATA_WIDTH-1:0]  rdata_o,
  input  logic [W_PORTS-1:0][AW-1:0]          waddr_i,
  input  logic [W_PORTS-1:0]                  we_i,
  input  logic [W_PORTS-1:0][DATA_WIDTH-1:0]  wdata_i
);

  logic [DATA_WIDTH-1:0] mem_q [DEPTH];
  logic                  wr_clash;

  // async read, a write shows up the cycle after its edge
  always_comb
  begin
    for (int r = 0; r < R_PORTS; r++)
    begin
      rdata_o[r] = mem_q[raddr_i[r]];
    end
  end

  // later ports override earlier ones
  always_ff @(posedge clk)
  begin
    for (int w = 0; w < W_PORTS; w++)
    begin
      if (we_i[w])
      begin
        mem_q[waddr_i[w]] <= wdata_i[w];
      end
    end
  end

  always_comb
  begin
    wr_clash = 1'b0;
    for (int i = 0; i < W_PORTS; i++)
    begin
      for (int j = i + 1; j < W_PORTS; j++)
      begin
        if (we_i[i] && we_i[j] && (waddr_i[i] == waddr_i[j]))
        begin
          wr_clash = 1'b1;
        end
      end
    end
  end

  // callers promise distinct write targets
  a_no_wr_clash: assert property (@(posedge clk) disable iff (!rst_n) !wr_clash);

endmodule

// File: design/rob_top.sv
`timescale 1ns/1ps

module rob_top import rob_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  word_t                paddr_i,
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  word_t                pwdata_i,
  output word_t                prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o,
  input  logic           [1:0] disp_valid_i,
  input  dispatch_info_t [1:0] disp_info_i,
  output logic                 disp_ready_o,
  output rob_rid_t       [1:0] disp_rid_o,
  input  cdb_t           [1:0] cdb_i,
  input  rob_rid_t       [3:0] op_rid_i,
  output logic           [3:0] op_done_o,
  output word_t          [3:0] op_data_o,
  output rob_entry_t     [1:0] commit_entry_o,
  output logic           [1:0] commit_valid_o,
  input  logic           [1:0] retire_i
);

  rob_cfg_t  cfg;   // apb block to core
  rob_stat_t stat;  // core back to apb block

  rob_core u_core (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_i         (cfg),
    .stat_o        (stat),
    .disp_valid_i  (disp_valid_i),
    .disp_info_i   (disp_info_i),
    .disp_ready_o  (disp_ready_o),
    .disp_rid_o    (disp_rid_o),
    .cdb_i         (cdb_i),
    .op_rid_i      (op_rid_i),
    .op_done_o     (op_done_o),
    .op_data_o     (op_data_o),
    .commit_entry_o(commit_entry_o),
    .commit_valid_o(commit_valid_o),
    .retire_i      (retire_i)
  );

  rob_cfg_apb u_cfg (
    .clk      (clk),
    .rst_n    (rst_n),
    .paddr_i  (paddr_i),
    .psel_i   (psel_i),
    .penable_i(penable_i),
    .pwrite_i (pwrite_i),
    .pwdata_i (pwdata_i),
    .prdata_o (prdata_o),
    .pready_o (pready_o),
    .pslverr_o(pslverr_o),
    .cfg_o    (cfg),
    .stat_i   (stat)
  );

endmodule

// File: design/rob_valid_tracker.sv
`timescale 1ns/1ps

module rob_valid_tracker import rob_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic     [1:0]       disp_we_i,
  input  rob_rid_t [1:0]       disp_rid_i,
  input  cdb_t     [1:0]       cdb_i,
  input  rob_rid_t [3:0]       op_rid_i,
  input  rob_rid_t [1:0]       head_rid_i,
  input  logic     [1:0]       retire_i,
  output logic     [3:0]       op_done_o,
  output logic     [1:0]       commit_valid_o,
  output logic     [ROB_LEN:0] occupancy_o
);

  localparam int DEPTH = 1 << ROB_LEN;
  localparam int CW    = ROB_LEN + 1;

  rob_rid_t [1:0] cdb_rid;
  logic     [1:0] cdb_we;
  logic     [7:0] dt_rd;    // dispatch flip bits
  logic     [7:0] ct_rd;    // cdb flip bits
  logic     [1:0] head_dt, head_ct;
  logic     [3:0] op_dt, op_ct;
  logic     [1:0] cdb_dt;   // dispatch bit seen at the cdb rid
  logic     [1:0] disp_ct;  // cdb bit seen at the dispatch rid
  logic     [1:0] alloc_q;
  logic [CW-1:0]  occ_q, occ_next;

  always_comb
  begin
    for (int i = 0; i < 2; i++)
    begin
      cdb_we[i]  = cdb_i[i].valid;
      cdb_rid[i] = cdb_i[i].rid;
    end
  end

  // copy the cdb bit on dispatch, so done reads 0
  rob_regfile_banked #(
    .DATA_WIDTH(1),
    .DEPTH     (DEPTH),
    .R_PORTS   (8),
    .W_PORTS   (2)
  ) u_disp_flip (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr_i({head_rid_i, op_rid_i, cdb_rid}),
    .rdata_o(dt_rd),
    .waddr_i(disp_rid_i),
    .we_i   (disp_we_i),
    .wdata_i(disp_ct)
  );

  // invert against the dispatch bit on writeback, done reads 1
  rob_regfile_banked #(
    .DATA_WIDTH(1),
    .DEPTH     (DEPTH),
    .R_PORTS   (8),
    .W_PORTS   (2)
  ) u_cdb_flip (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr_i({head_rid_i, op_rid_i, disp_rid_i}),
    .rdata_o(ct_rd),
    .waddr_i(cdb_rid),
    .we_i   (cdb_we),
    .wdata_i(~cdb_dt)
  );

  assign {head_dt, op_dt, cdb_dt}  = dt_rd;
  assign {head_ct, op_ct, disp_ct} = ct_rd;

  assign op_done_o      = op_dt ^ op_ct;
  assign commit_valid_o = alloc_q & (head_dt ^ head_ct);

  assign occ_next = occ_q + CW'(disp_we_i[0]) + CW'(disp_we_i[1])
                  - CW'(retire_i[0]) - CW'(retire_i[1]);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      occ_q   <= '0;
      alloc_q <= '0;
    end
    else
    begin
      occ_q      <= occ_next;
      alloc_q[0] <= occ_next >= CW'(1);  // head slot allocated
      alloc_q[1] <= occ_next >= CW'(2);
    end
  end

  assign occupancy_o = occ_q;

  a_occ_bound: assert property (@(posedge clk) disable iff (!rst_n) occ_q <= CW'(DEPTH));

  // commit stage may only take entries that are finished
  a_retire_done: assert property (@(posedge clk) disable iff (!rst_n)
    (retire_i & ~commit_valid_o) == 2'b00);

endmodule

// File: run.sh
#!/bin/sh
# build and run the rob testbench with verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module rob_tb -f src.f -o rob_sim > build.log 2>&1 \
  || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/rob_sim > sim.log 2>&1 || echo "Some tests failed" >> sim.log
cat sim.log
grep -q "Some tests failed" sim.log && exit 1
exit 0

// File: src.f
design/rob_pkg.sv
design/rob_regfile_banked.sv
design/rob_valid_tracker.sv
design/rob_pointers.sv
design/rob_core.sv
design/rob_cfg_apb.sv
design/rob_top.sv
testbench/rob_tb.sv

// File: testbench/rob_tb.sv
`timescale 1ns/1ps

module rob_tb import rob_pkg::*;;

  localparam int    RAND_CYCLES    = 400;
  localparam int    TIMEOUT_CYCLES = 5 * (RAND_CYCLES + 400);  // random phase plus fills and drains
  localparam word_t ADDR_CTRL      = 32'h0;
  localparam word_t ADDR_STATUS    = 32'h4;
  localparam word_t ADDR_RETIRED   = 32'h8;
  localparam word_t ADDR_UNMAPPED  = 32'hC;

  logic                 clk;
  logic                 rst_n;
  word_t                paddr_i;
  logic                 psel_i;
  logic                 penable_i;
  logic                 pwrite_i;
  word_t                pwdata_i;
  word_t                prdata_o;
  logic                 pready_o;
  logic                 pslverr_o;
  logic           [1:0] disp_valid_i;
  dispatch_info_t [1:0] disp_info_i;
  logic                 disp_ready_o;
  rob_rid_t       [1:0] disp_rid_o;
  cdb_t           [1:0] cdb_i;
  rob_rid_t       [3:0] op_rid_i;
  logic           [3:0] op_done_o;
  word_t          [3:0] op_data_o;
  rob_entry_t     [1:0] commit_entry_o;
  logic           [1:0] commit_valid_o;
  logic           [1:0] retire_i;

  // reference model, indexed by rid
  dispatch_info_t ref_info [8];
  word_t          ref_data [8];
  logic           ref_jump [8];
  word_t          ref_tgt  [8];
  bit             ref_done [8];
  int             ord_q [$];  // allocated rids, oldest first
  int             wb_q [$];   // allocated, no writeback yet
  int             tail_cnt, retired_cnt;
  bit             ref_en;
  int             ref_reserve;

  string      test_name;
  int         err_cnt, err_base, pass_cnt, fail_cnt;
  int         cyc_cnt, ready_low_seen, seen_zero, seen_one, retire_base;
  bit         cmp_en;
  rob_entry_t exp_e;
  word_t      rdata;
  logic       rerr;
  bit         ok;

  rob_top dut_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic dispatch_info_t rand_info();
    dispatch_info_t d;
    d.pc   = $urandom;
    d.wreg = arch_rid_t'($urandom);
    d.excp = excp_t'($urandom);
    return d;
  endfunction

  // expected commit entry for head slot k
  function automatic rob_entry_t expected_head(input int k);
    rob_entry_t e;
    int         rid;
    e = '0;
    if (ord_q.size() > k)
    begin
      rid         = ord_q[k];
      e.valid     = ref_done[rid];
      e.pc        = ref_info[rid].pc;
      e.wreg      = ref_info[rid].wreg;
      e.excp      = ref_info[rid].excp;
      e.wdata     = ref_data[rid];
      e.need_jump = ref_jump[rid];
      e.target    = ref_tgt[rid];
    end
    return e;
  endfunction

  task automatic compare(input string label, input logic [127:0] exp_v,
                         input logic [127:0] act_v);
    if (exp_v !== act_v)
    begin
      $display("CHECK FAILED %s/%s expected %0h actual %0h", test_name, label, exp_v, act_v);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input bit extra_ok);
    if (err_cnt == err_base && extra_ok)
    begin
      pass_cnt++;
      $display("test %s: ok", test_name);
    end
    else
    begin
      fail_cnt++;
      $display("test %s: FAIL", test_name);
    end
    err_base = err_cnt;
  endtask

  task automatic idle_inputs();
    disp_valid_i = 2'b00;
    retire_i     = 2'b00;
    cdb_i        = '0;
  endtask

  task automatic apb_write(input word_t addr, input word_t data);
    @(negedge clk);
    idle_inputs();
    paddr_i   = addr;
    pwdata_i  = data;
    pwrite_i  = 1'b1;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    @(negedge clk);
    penable_i = 1'b1;  // access phase, pready is tied high
    @(negedge clk);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_read(input word_t addr, output word_t data, output logic err);
    @(negedge clk);
    idle_inputs();
    paddr_i   = addr;
    pwrite_i  = 1'b0;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    @(negedge clk);
    penable_i = 1'b1;
    #1;
    data = prdata_o;
    err  = pslverr_o;
    compare("pready", 128'(1), 128'(pready_o));  // no wait states
    @(negedge clk);
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  // one clock of dispatch, writeback, retire and operand reads
  task automatic run_cycle(input bit try_disp, input bit try_retire, input bit try_cdb);
    logic [1:0] offer;
    logic [1:0] took;
    logic [1:0] ret;
    bit   [3:0] op_chk;
    bit         ref_ready;
    int         idx;
    int         rid;
    @(negedge clk);
    ref_ready = ref_en && (8 - ord_q.size() >= 2 + ref_reserve);
    compare("disp_ready", 128'(ref_ready), 128'(disp_ready_o));
    compare("disp_rid", 128'(tail_cnt % 8), 128'(disp_rid_o[0]));
    compare("disp_rid1", 128'((tail_cnt + 1) % 8), 128'(disp_rid_o[1]));
    if (!disp_ready_o)
      ready_low_seen++;
    offer = 2'b00;
    if (try_disp)
      offer = ($urandom % 4 == 0) ? 2'b01 : 2'b11;
    disp_valid_i   = offer;
    disp_info_i[0] = rand_info();
    disp_info_i[1] = rand_info();
    took           = offer & {2{disp_ready_o}};
    ret = 2'b00;
    if (try_retire && commit_valid_o[0])
      ret = commit_valid_o[1] ? 2'b11 : 2'b01;
    retire_i = ret;
    cdb_i    = '0;
    for (int p = 0; p < 2; p++)
    begin
      if (try_cdb && wb_q.size() > 0 && $urandom % 2 == 0)
      begin
        idx = $urandom % wb_q.size();  // shuffled writeback order
        rid = wb_q[idx];
        wb_q.delete(idx);
        cdb_i[p].valid     = 1'b1;
        cdb_i[p].rid       = rob_rid_t'(rid);
        cdb_i[p].wdata     = $urandom;
        cdb_i[p].need_jump = 1'($urandom);
        cdb_i[p].target    = $urandom;
      end
    end
    op_chk = '0;
    for (int p = 0; p < 4; p++)
    begin
      op_rid_i[p] = rob_rid_t'($urandom);
      if (ord_q.size() > 0)
      begin
        op_rid_i[p] = rob_rid_t'(ord_q[$urandom % ord_q.size()]);
        op_chk[p]   = 1'b1;
      end
    end
    #1;
    for (int p = 0; p < 4; p++)
    begin
      if (op_chk[p])
      begin
        rid = int'(op_rid_i[p]);
        compare("op_done", 128'(ref_done[rid]), 128'(op_done_o[p]));
        if (ref_done[rid])
        begin
          compare("op_data", 128'(ref_data[rid]), 128'(op_data_o[p]));
          seen_one++;
        end
        else
          seen_zero++;
      end
    end
    @(posedge clk);
    #1;
    for (int s = 0; s < 2; s++)
    begin
      if (took[s])
      begin
        rid           = tail_cnt % 8;
        ref_info[rid] = disp_info_i[s];
        ref_done[rid] = 1'b0;
        ord_q.push_back(rid);
        wb_q.push_back(rid);
        tail_cnt++;
      end
    end
    for (int p = 0; p < 2; p++)
    begin
      if (cdb_i[p].valid)
      begin
        rid           = int'(cdb_i[p].rid);
        ref_data[rid] = cdb_i[p].wdata;
        ref_jump[rid] = cdb_i[p].need_jump;
        ref_tgt[rid]  = cdb_i[p].target;
        ref_done[rid] = 1'b1;
      end
    end
    for (int s = 0; s < 2; s++)
    begin
      if (ret[s])
      begin
        void'(ord_q.pop_front());
        retired_cnt++;
      end
    end
  endtask

  task automatic drain();
    while (ord_q.size() > 0)
      run_cycle(1'b0, 1'b1, 1'b1);
  endtask

  // head entries against the model, every cycle
  always @(negedge clk)
  begin
    if (cmp_en)
    begin
      for (int k = 0; k < 2; k++)
      begin
        exp_e = expected_head(k);
        compare("commit_valid", 128'(exp_e.valid), 128'(commit_valid_o[k]));
        if (exp_e.valid)
          compare("commit_entry", 128'(exp_e), 128'(commit_entry_o[k]));
      end
    end
  end

  always @(posedge clk)
  begin
    cyc_cnt++;
    if (cyc_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, the run did not complete", cyc_cnt);
      $display("Some tests failed");
      $finish;
    end
  end

  initial
  begin
    void'($urandom(81));
    rst_n     = 1'b0;
    paddr_i   = '0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    pwdata_i  = '0;
    disp_info_i = '0;
    op_rid_i  = '0;
    idle_inputs();
    ref_en      = 1'b1;
    ref_reserve = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n  = 1'b1;
    cmp_en = 1'b1;

    test_name = "reset";
    @(negedge clk);
    compare("commit_valid", 128'(0), 128'(commit_valid_o));
    compare("disp_ready", 128'(1), 128'(disp_ready_o));
    compare("pslverr", 128'(0), 128'(pslverr_o));
    apb_read(ADDR_STATUS, rdata, rerr);
    compare("status", 128'(0), 128'(rdata));
    apb_read(ADDR_RETIRED, rdata, rerr);
    compare("retired", 128'(0), 128'(rdata));
    finish_test(1'b1);

    test_name   = "random_traffic";
    retire_base = retired_cnt;
    repeat (RAND_CYCLES) run_cycle(1'b1, 1'b1, 1'b1);
    drain();
    finish_test(retired_cnt - retire_base > RAND_CYCLES / 4);

    test_name = "operand_read";
    seen_zero = 0;
    seen_one  = 0;
    repeat (40) run_cycle(1'b1, 1'b1, 1'b1);
    drain();
    finish_test(seen_zero > 0 && seen_one > 0);

    test_name      = "fill";
    ready_low_seen = 0;
    repeat (8) run_cycle(1'b1, 1'b0, 1'b0);
    ok = ready_low_seen > 0;
    apb_read(ADDR_STATUS, rdata, rerr);
    compare("status_full", 128'(ord_q.size()), 128'(rdata));
    drain();
    apb_write(ADDR_CTRL, 32'h21);  // reserve 2, dispatch on
    ref_reserve    = 2;
    ready_low_seen = 0;
    repeat (8) run_cycle(1'b1, 1'b0, 1'b0);
    ok = ok && ready_low_seen > 0;
    apb_read(ADDR_STATUS, rdata, rerr);
    compare("status_reserve", 128'(ord_q.size()), 128'(rdata));
    drain();
    apb_write(ADDR_CTRL, 32'h1);
    ref_reserve = 0;
    finish_test(ok);

    test_name = "disable_and_counters";
    apb_write(ADDR_CTRL, 32'h0);
    ref_en         = 1'b0;
    ready_low_seen = 0;
    repeat (4) run_cycle(1'b1, 1'b0, 1'b0);
    ok = ready_low_seen == 4;
    apb_read(ADDR_STATUS, rdata, rerr);
    compare("status_idle", 128'(0), 128'(rdata));
    apb_write(ADDR_CTRL, 32'h1);
    ref_en = 1'b1;
    apb_read(ADDR_RETIRED, rdata, rerr);
    compare("retired", 128'(retired_cnt), 128'(rdata));
    compare("pslverr_mapped", 128'(0), 128'(rerr));
    apb_write(ADDR_RETIRED, 32'h0);
    apb_read(ADDR_RETIRED, rdata, rerr);
    compare("retired_clr", 128'(0), 128'(rdata));
    apb_read(ADDR_UNMAPPED, rdata, rerr);
    compare("pslverr_unmapped", 128'(1), 128'(rerr));
    finish_test(ok);

    $display("summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule
